// File: design/ahb_bus_pkg.sv
// ====================================================================
// Bus-level widths and burst codes for the shared-memory subsystem
// Addresses are byte addresses with a word stride of 4
// Only SINGLE and INCR bursts exist, no WRAP codes
// ====================================================================

`default_nettype none

package ahb_bus_pkg;

  // ====================================================================
  // Burst encoding
  // ====================================================================

  // Two-bit code, not the 3-bit AHB HBURST field
  typedef enum logic [1:0] {
    SINGLE = 2'b00,
    INCR4  = 2'b01,
    INCR8  = 2'b10,
    INCR16 = 2'b11
  } hburst_type;

  // ====================================================================
  // Address and data
  // ====================================================================

  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] haddr_t;
  typedef logic [DATA_W-1:0] hdata_t;

  // ====================================================================
  // Memory geometry
  // ====================================================================

  // 64 words fill the whole 8-bit byte address space
  localparam int MEM_WORDS = 64;
  localparam int IDX_W     = $clog2(MEM_WORDS);

  typedef logic [IDX_W-1:0] mem_idx_t;

endpackage

`default_nettype wire

// File: design/arb_pkg.sv
// ====================================================================
// Arbitration constants for the two-master round-robin arbiter
// Beat counter is 4 bits, enough for INCR16
// ====================================================================

`default_nettype none

package arb_pkg;

  localparam int MASTER_NUM = 2;
  localparam int PRIOR_BIT  = 1;
  localparam int BEAT_W     = 4;

  typedef logic [MASTER_NUM-1:0] master_vec_t;
  typedef logic [PRIOR_BIT-1:0]  prior_t;
  typedef logic [BEAT_W-1:0]     beat_cnt_t;

  // Index of the final beat for a burst type
  function automatic beat_cnt_t burst_limit(ahb_bus_pkg::hburst_type burst);
    case (burst)
      ahb_bus_pkg::INCR4:  return beat_cnt_t'(3);
      ahb_bus_pkg::INCR8:  return beat_cnt_t'(7);
      ahb_bus_pkg::INCR16: return beat_cnt_t'(15);
      default:             return beat_cnt_t'(0);
    endcase
  endfunction

endpackage

`default_nettype wire

// File: design/burst_monitor.sv
// ====================================================================
// Counts accepted beats of the burst now on the bus
// monitor_last is combinational and already valid in the first beat
// hburst must stay stable while the owner is unchanged
// ====================================================================

`default_nettype none

module burst_monitor (
  input  wire                      hclk,
  input  wire                      hreset_n,
  input  logic                     hsel,
  input  logic                     hwait,
  input  ahb_bus_pkg::hburst_type  hburst,
  output logic                     monitor_last
);

  import arb_pkg::*;

  typedef enum logic {
    IDLE,
    MONITOR
  } mon_state_t;

  mon_state_t mon_state;
  mon_state_t mon_state_next;
  beat_cnt_t  count;
  beat_cnt_t  count_limit;
  logic       beat_accept;
  logic       last_accept;
  logic       count_clr;

  assign count_limit  = burst_limit(hburst);
  assign beat_accept  = hsel & ~hwait;
  assign monitor_last = hsel & (count == count_limit);
  assign last_accept  = beat_accept & monitor_last;

  // Bus dropped without a burst running, start from zero
  assign count_clr = last_accept | ((mon_state == IDLE) & ~hsel);

  always_comb
  begin
    mon_state_next = mon_state;
    case (mon_state)
      IDLE:
      begin
        // A SINGLE can finish in the very cycle hsel rises
        if (hsel && !last_accept)
          mon_state_next = MONITOR;
      end
      MONITOR:
      begin
        if (last_accept || !hsel)
          mon_state_next = IDLE;
      end
      default: mon_state_next = IDLE;
    endcase
  end

  always_ff @(posedge hclk or negedge hreset_n)
  begin
    if (!hreset_n)
      mon_state <= IDLE;
    else
      mon_state <= mon_state_next;
  end

  always_ff @(posedge hclk or negedge hreset_n)
  begin
    if (!hreset_n)
      count <= '0;
    else if (count_clr || (mon_state == MONITOR && !hsel))
      count <= '0;
    else if (beat_accept)
      count <= count + 1'b1;
  end

endmodule

`default_nettype wire

// File: design/slave_arbiter.sv
// ====================================================================
// Round-robin arbiter for one slave, grant registered and held
// until the owner's last beat is accepted
// Highest priority value wins, the finished owner drops to zero
// ====================================================================

`default_nettype none

module slave_arbiter (
  input  wire                      hclk,
  input  wire                      hreset_n,
  input  arb_pkg::master_vec_t     hreq,
  input  ahb_bus_pkg::hburst_type  hburst,
  input  logic                     hwait,
  output arb_pkg::master_vec_t     hgrant,
  output arb_pkg::master_vec_t     grant,
  output logic                     hsel
);

  import arb_pkg::*;

  prior_t      prior_reg [MASTER_NUM];
  prior_t      prior_next [MASTER_NUM];
  prior_t      owner_prior;
  prior_t      best_prior;
  master_vec_t hlast;
  master_vec_t cand_req;
  master_vec_t win_grant;
  master_vec_t next_grant;
  logic        monitor_last;
  logic        update;
  logic        found;

  burst_monitor u_monitor (
    .hclk         (hclk),
    .hreset_n     (hreset_n),
    .hsel         (hsel),
    .hwait        (hwait),
    .hburst       (hburst),
    .monitor_last (monitor_last)
  );

  assign hlast  = grant & {MASTER_NUM{monitor_last}};
  assign update = hsel & ~hwait & (|hlast);

  // ==================================================================
  // Priority table
  // ==================================================================

  always_comb
  begin
    owner_prior = '0;
    for (int i = 0; i < MASTER_NUM; i++)
    begin
      if (grant[i])
        owner_prior = prior_reg[i];
    end
    for (int i = 0; i < MASTER_NUM; i++)
    begin
      prior_next[i] = prior_reg[i];
      if (grant[i])
        prior_next[i] = '0;
      else if (prior_reg[i] < owner_prior)
        prior_next[i] = prior_reg[i] + 1'b1;
    end
  end

  always_ff @(posedge hclk or negedge hreset_n)
  begin
    for (int i = 0; i < MASTER_NUM; i++)
    begin
      if (!hreset_n)
        prior_reg[i] <= prior_t'(i);
      else if (update)
        prior_reg[i] <= prior_next[i];
    end
  end

  // ==================================================================
  // Winner selection and grant register
  // ==================================================================

  // Owner finishing this cycle drops hreq at the same edge
  assign cand_req = hreq & ~(update ? grant : '0);

  always_comb
  begin
    win_grant  = '0;
    best_prior = '0;
    found      = 1'b0;
    for (int i = 0; i < MASTER_NUM; i++)
    begin
      if (cand_req[i] && (!found || prior_reg[i] > best_prior))
      begin
        win_grant    = '0;
        win_grant[i] = 1'b1;
        best_prior   = prior_reg[i];
        found        = 1'b1;
      end
    end
  end

  // Re-arbitrate only on an idle bus or on the owner's last beat
  assign next_grant = (!hsel || update) ? win_grant : grant;

  always_ff @(posedge hclk or negedge hreset_n)
  begin
    if (!hreset_n)
      grant <= '0;
    else
      grant <= next_grant;
  end

  assign hgrant = grant & ~{MASTER_NUM{hwait}};
  assign hsel   = |grant;

endmodule

`default_nettype wire

// File: design/burst_master.sv
// ====================================================================
// Write-burst master, one command at a time
// Address steps by 4 per beat, data by 1 per beat from the seed
// A start pulse while busy is dropped
// ====================================================================

`default_nettype none

module burst_master (
  input  wire                      hclk,
  input  wire                      hreset_n,
  input  logic                     start,
  input  ahb_bus_pkg::hburst_type  burst,
  input  ahb_bus_pkg::haddr_t      base_addr,
  input  ahb_bus_pkg::hdata_t      seed_data,
  input  logic                     hgrant,
  output logic                     hreq,
  output ahb_bus_pkg::haddr_t      m_addr,
  output ahb_bus_pkg::hdata_t      m_wdata,
  output ahb_bus_pkg::hburst_type  m_burst,
  output logic                     done
);

  import ahb_bus_pkg::*;
  import arb_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    DONE
  } mst_state_t;

  mst_state_t state;
  mst_state_t state_next;
  hburst_type burst_q;
  haddr_t     base_q;
  hdata_t     seed_q;
  beat_cnt_t  beat;
  logic       last_beat;

  assign last_beat = (beat == burst_limit(burst_q));

  always_comb
  begin
    state_next = state;
    case (state)
      IDLE:    if (start) state_next = REQUEST;
      REQUEST: if (hgrant && last_beat) state_next = DONE;
      DONE:    state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge hclk or negedge hreset_n)
  begin
    if (!hreset_n)
      state <= IDLE;
    else
      state <= state_next;
  end

  // Beat index advances only on accepted beats
  always_ff @(posedge hclk or negedge hreset_n)
  begin
    if (!hreset_n)
      beat <= '0;
    else if (state == IDLE && start)
      beat <= '0;
    else if (state == REQUEST && hgrant)
      beat <= beat + 1'b1;
  end

  // Command capture
  always_ff @(posedge hclk)
  begin
    if (state == IDLE && start)
    begin
      burst_q <= burst;
      base_q  <= base_addr;
      seed_q  <= seed_data;
    end
  end

  assign hreq    = (state == REQUEST);
  assign done    = (state == DONE);
  assign m_addr  = base_q + haddr_t'({beat, 2'b00});
  assign m_wdata = seed_q + hdata_t'(beat);
  assign m_burst = burst_q;

endmodule

`default_nettype wire

// File: design/sram_slave.sv
// ====================================================================
// Word-addressed write memory, one wait state on each odd word
// Byte offset bits of haddr are ignored
// Side read port is combinational and for inspection only
// ====================================================================

`default_nettype none

module sram_slave (
  input  wire                  hclk,
  input  wire                  hreset_n,
  input  logic                 hsel,
  input  ahb_bus_pkg::haddr_t  haddr,
  input  ahb_bus_pkg::hdata_t  hwdata,
  output logic                 hwait,
  input  ahb_bus_pkg::mem_idx_t dbg_idx,
  output ahb_bus_pkg::hdata_t  dbg_rdata
);

  import ahb_bus_pkg::*;

  hdata_t   mem [MEM_WORDS];
  mem_idx_t word_idx;
  logic     odd_word;
  logic     wait_spent;
  logic     beat_accept;

  assign word_idx = mem_idx_t'(haddr[ADDR_W-1:2]);
  assign odd_word = word_idx[0];

  // ==================================================================
  // Slow bank model
  // ==================================================================

  // First cycle of an odd beat stalls, second one completes
  assign hwait = hsel & odd_word & ~wait_spent;

  always_ff @(posedge hclk or negedge hreset_n)
  begin
    if (!hreset_n)
      wait_spent <= 1'b0;
    else
      wait_spent <= hwait;
  end

  // ==================================================================
  // Storage
  // ==================================================================

  assign beat_accept = hsel & ~hwait;

  always_ff @(posedge hclk)
  begin
    if (beat_accept)
      mem[word_idx] <= hwdata;
  end

  assign dbg_rdata = mem[dbg_idx];

endmodule

`default_nettype wire

// File: design/ahb_subsys_top.sv
// ====================================================================
// Two write masters sharing one SRAM slave through a round-robin
// arbiter, bus multiplexed by the registered grant
// Per-master inputs and outputs are indexed by master number
// ====================================================================

`default_nettype none

module ahb_subsys_top (
  input  wire                      hclk,
  input  wire                      hreset_n,
  input  arb_pkg::master_vec_t     start,
  input  ahb_bus_pkg::hburst_type  burst [arb_pkg::MASTER_NUM],
  input  ahb_bus_pkg::haddr_t      base_addr [arb_pkg::MASTER_NUM],
  input  ahb_bus_pkg::hdata_t      seed_data [arb_pkg::MASTER_NUM],
  output arb_pkg::master_vec_t     done,
  output arb_pkg::master_vec_t     hreq_out,
  output arb_pkg::master_vec_t     hgrant_out,
  output logic                     hsel_out,
  output logic                     hwait_out,
  input  ahb_bus_pkg::mem_idx_t    dbg_idx,
  output ahb_bus_pkg::hdata_t      dbg_rdata
);

  import ahb_bus_pkg::*;
  import arb_pkg::*;

  haddr_t      m_addr [MASTER_NUM];
  hdata_t      m_wdata [MASTER_NUM];
  hburst_type  m_burst [MASTER_NUM];
  master_vec_t grant_vec;
  haddr_t      haddr;
  hdata_t      hwdata;
  hburst_type  hburst;

  for (genvar i = 0; i < MASTER_NUM; i++)
  begin : g_master
    burst_master u_master (
      .hclk      (hclk),
      .hreset_n  (hreset_n),
      .start     (start[i]),
      .burst     (burst[i]),
      .base_addr (base_addr[i]),
      .seed_data (seed_data[i]),
      .hgrant    (hgrant_out[i]),
      .hreq      (hreq_out[i]),
      .m_addr    (m_addr[i]),
      .m_wdata   (m_wdata[i]),
      .m_burst   (m_burst[i]),
      .done      (done[i])
    );
  end

  // Owner's signals onto the shared bus
  always_comb
  begin
    haddr  = '0;
    hwdata = '0;
    hburst = SINGLE;
    for (int i = 0; i < MASTER_NUM; i++)
    begin
      if (grant_vec[i])
      begin
        haddr  = m_addr[i];
        hwdata = m_wdata[i];
        hburst = m_burst[i];
      end
    end
  end

  slave_arbiter u_arbiter (
    .hclk     (hclk),
    .hreset_n (hreset_n),
    .hreq     (hreq_out),
    .hburst   (hburst),
    .hwait    (hwait_out),
    .hgrant   (hgrant_out),
    .grant    (grant_vec),
    .hsel     (hsel_out)
  );

  sram_slave u_sram (
    .hclk      (hclk),
    .hreset_n  (hreset_n),
    .hsel      (hsel_out),
    .haddr     (haddr),
    .hwdata    (hwdata),
    .hwait     (hwait_out),
    .dbg_idx   (dbg_idx),
    .dbg_rdata (dbg_rdata)
  );

endmodule

`default_nettype wire

// File: dv/tb_ahb_subsys.sv
// ======================================================================
// Testbench for the two-master shared SRAM subsystem
// Each master writes only its own half of the memory, so the reference
// contents of a burst are final once its command is issued
// ======================================================================

`default_nettype none

module tb_ahb_subsys;

  timeunit 1ns;
  timeprecision 100ps;

  import ahb_bus_pkg::*;
  import arb_pkg::*;

  localparam int CMD_NUM        = 16;
  localparam int CMD_PER_MASTER = CMD_NUM / MASTER_NUM;
  localparam int REGION_WORDS   = MEM_WORDS / MASTER_NUM;
  localparam int TIMEOUT_CYCLES = CMD_NUM * 40 + 400;

  logic        hclk;
  logic        hreset_n;
  master_vec_t start;
  hburst_type  burst [MASTER_NUM];
  haddr_t      base_addr [MASTER_NUM];
  hdata_t      seed_data [MASTER_NUM];
  master_vec_t done;
  master_vec_t hreq_out;
  master_vec_t hgrant_out;
  logic        hsel_out;
  logic        hwait_out;
  mem_idx_t    dbg_idx;
  hdata_t      dbg_rdata;

  // Command list and reference memory
  hburst_type  cmd_burst [CMD_NUM];
  haddr_t      cmd_base [CMD_NUM];
  hdata_t      cmd_seed [CMD_NUM];
  int          cmd_gap [CMD_NUM];
  hdata_t      ref_mem [MEM_WORDS];
  int          seed;
  int          cycle_count = 0;

  // Bus ownership model
  int          cur_len [MASTER_NUM];
  int          cur_odd [MASTER_NUM];
  int          owner;
  int          next_owner;
  int          last_owner;
  logic        in_tenure;
  logic        arb_next;
  int          beats_seen;
  int          owned_cycles;
  int          wait_cycles;
  master_vec_t done_exp;
  master_vec_t req_exp;
  int          check_q [$];
  logic        checked [MASTER_NUM];

  ahb_subsys_top DUT (
    .hclk       (hclk),
    .hreset_n   (hreset_n),
    .start      (start),
    .burst      (burst),
    .base_addr  (base_addr),
    .seed_data  (seed_data),
    .done       (done),
    .hreq_out   (hreq_out),
    .hgrant_out (hgrant_out),
    .hsel_out   (hsel_out),
    .hwait_out  (hwait_out),
    .dbg_idx    (dbg_idx),
    .dbg_rdata  (dbg_rdata)
  );

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp)
    else abort_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic check_true(logic cond, string why);
    assert (cond)
    else abort_run(why);
  endtask

  function automatic int burst_beats(hburst_type b);
    case (b)
      SINGLE:  return 1;
      INCR4:   return 4;
      INCR8:   return 8;
      default: return 16;
    endcase
  endfunction

  // Beats of a burst that land on an odd word
  function automatic int odd_beats(haddr_t base, int len);
    int n;
    n = 0;
    for (int k = 0; k < len; k++)
    begin
      if ((int'(base >> 2) + k) % 2 == 1)
        n++;
    end
    return n;
  endfunction

  // On a tie between the two masters the last owner loses
  function automatic void pick_owner(master_vec_t cand);
    arb_next = (cand != '0);
    if (&cand)
      next_owner = 1 - last_owner;
    else if (cand[1])
      next_owner = 1;
    else
      next_owner = 0;
  endfunction

  // ======================================================================
  // Clock, timeout and bus properties
  // ======================================================================

  initial
  begin
    hclk = 1'b0;
    forever
    begin
      #5 hclk = ~hclk;
    end
  end

  always @(posedge hclk)
  begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES)
      abort_run($sformatf("Timeout: run did not finish in %0d cycles", TIMEOUT_CYCLES));
  end

  a_one_grant: assert property (@(posedge hclk) disable iff (!hreset_n)
    $onehot0(hgrant_out))
    else abort_run($sformatf("FAILED hgrant_out: 0x%0h holds two grants", hgrant_out));

  a_wait_blocks_grant: assert property (@(posedge hclk) disable iff (!hreset_n)
    hwait_out |-> (hgrant_out == '0))
    else abort_run($sformatf("FAILED hgrant_out: got 0x%0h in a wait state, expected 0x0",
                             hgrant_out));

  a_wait_one_cycle: assert property (@(posedge hclk) disable iff (!hreset_n)
    hwait_out |=> !hwait_out)
    else abort_run("FAILED hwait_out: got 0x1 in a second cycle, expected 0x0");

  // ======================================================================
  // Ownership, burst length and done timing at the falling edge
  // ======================================================================

  always @(negedge hclk)
  begin
    if (hreset_n)
    begin
      check_value("done", 32'(done), 32'(done_exp));
      check_value("hreq_out", 32'(hreq_out), 32'(req_exp));
      done_exp = '0;
      if (arb_next)
      begin
        check_true(hsel_out, "Bus was not selected after an arbitration win");
        owner        = next_owner;
        in_tenure    = 1'b1;
        arb_next     = 1'b0;
        beats_seen   = 0;
        owned_cycles = 0;
        wait_cycles  = 0;
      end
      if (in_tenure)
      begin
        check_true(hsel_out, "Bus was deselected in the middle of a burst");
        owned_cycles++;
        if (hwait_out)
          wait_cycles++;
        if (!hwait_out)
        begin
          check_value("hgrant_out", 32'(hgrant_out), 32'(1 << owner));
          beats_seen++;
          if (beats_seen == cur_len[owner])
          begin
            check_value("owned_cycles", owned_cycles, cur_len[owner] + cur_odd[owner]);
            check_value("hwait_cycles", wait_cycles, cur_odd[owner]);
            done_exp[owner] = 1'b1;
            req_exp[owner]  = 1'b0;
            last_owner      = owner;
            in_tenure       = 1'b0;
            pick_owner(req_exp);
          end
        end
      end
      else
      begin
        check_true(!hsel_out, "Bus was selected without an arbitration win");
        pick_owner(req_exp);
      end
    end
  end

  // ======================================================================
  // Stimulus
  // ======================================================================

  task automatic build_commands();
    int len;
    int offset;
    for (int c = 0; c < CMD_NUM; c++)
    begin
      // First four commands of each master walk through every burst type
      if (c % CMD_PER_MASTER < 4)
        cmd_burst[c] = hburst_type'(2'(c));
      else
        cmd_burst[c] = hburst_type'(2'($random(seed)));
      len          = burst_beats(cmd_burst[c]);
      offset       = int'($unsigned($random(seed)) % (REGION_WORDS - len + 1));
      cmd_base[c]  = haddr_t'(4 * ((c / CMD_PER_MASTER) * REGION_WORDS + offset));
      cmd_seed[c]  = $random(seed);
      cmd_gap[c]   = (c % CMD_PER_MASTER == 0) ? 0 : int'($unsigned($random(seed)) % 4);
    end
  endtask

  task automatic issue_command(int m, int c);
    int len;
    int word;
    len = burst_beats(cmd_burst[c]);
    @(posedge hclk);
    #1;
    start[m]     = 1'b1;
    burst[m]     = cmd_burst[c];
    base_addr[m] = cmd_base[c];
    seed_data[m] = cmd_seed[c];
    cur_len[m]   = len;
    cur_odd[m]   = odd_beats(cmd_base[c], len);
    for (int k = 0; k < len; k++)
    begin
      word          = int'(cmd_base[c] >> 2) + k;
      ref_mem[word] = cmd_seed[c] + hdata_t'(k);
    end
    @(posedge hclk);
    #1;
    start[m] = 1'b0;
    // Request is up one cycle after the start pulse
    req_exp[m] = 1'b1;
  endtask

  task automatic run_master(int m);
    int c;
    for (int n = 0; n < CMD_PER_MASTER; n++)
    begin
      c = m * CMD_PER_MASTER + n;
      repeat (cmd_gap[c]) @(posedge hclk);
      issue_command(m, c);
      @(negedge hclk);
      while (!done[m])
        @(negedge hclk);
      checked[m] = 1'b0;
      check_q.push_back(c);
      while (!checked[m])
        @(posedge hclk);
    end
  endtask

  // Memory readback after each done pulse at one word per cycle
  initial
  begin : readback
    int c;
    int word;
    forever
    begin
      while (check_q.size() == 0)
        @(posedge hclk);
      c = check_q.pop_front();
      for (int k = 0; k < burst_beats(cmd_burst[c]); k++)
      begin
        word = int'(cmd_base[c] >> 2) + k;
        @(posedge hclk);
        #1;
        dbg_idx = mem_idx_t'(word);
        @(negedge hclk);
        check_value("dbg_rdata", dbg_rdata, ref_mem[word]);
      end
      checked[c / CMD_PER_MASTER] = 1'b1;
    end
  end

  task automatic check_reset_outputs();
    check_value("hgrant_out", 32'(hgrant_out), 32'h0);
    check_value("hsel_out", 32'(hsel_out), 32'h0);
    check_value("done", 32'(done), 32'h0);
    check_value("hwait_out", 32'(hwait_out), 32'h0);
  endtask

  initial
  begin
    seed       = 32'h32e7_b508;
    hreset_n   = 1'b0;
    start      = '0;
    dbg_idx    = '0;
    in_tenure  = 1'b0;
    arb_next   = 1'b0;
    last_owner = 0;
    owner      = 0;
    next_owner = 0;
    done_exp   = '0;
    req_exp    = '0;
    for (int i = 0; i < MASTER_NUM; i++)
    begin
      burst[i]     = SINGLE;
      base_addr[i] = '0;
      seed_data[i] = '0;
      cur_len[i]   = 1;
      cur_odd[i]   = 0;
      checked[i]   = 1'b0;
    end
    build_commands();
    repeat (4) @(posedge hclk);
    @(negedge hclk);
    check_reset_outputs();
    @(posedge hclk);
    #1;
    hreset_n = 1'b1;
    @(negedge hclk);
    check_reset_outputs();
    fork
      run_master(0);
      run_master(1);
    join
    repeat (4) @(posedge hclk);
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
design/ahb_bus_pkg.sv
design/arb_pkg.sv
design/burst_monitor.sv
design/slave_arbiter.sv
design/burst_master.sv
design/sram_slave.sv
design/ahb_subsys_top.sv
dv/tb_ahb_subsys.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_ahb_subsys -f src.f

sim_out=$(./obj_dir/Vtb_ahb_subsys 2>&1 || true)
echo "$sim_out"

if echo "$sim_out" | grep -q "Regression passed"; then
  exit 0
fi
exit 1
